// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    localparam int word_bits       = 32;
    localparam int mask_bits       = 4;   // one enable per byte
    localparam int line_bits       = 256;
    localparam int burst_bits      = 64;
    localparam int bursts_per_line = 4;
    localparam int offset_bits     = 5;   // byte offset in a line
    localparam int index_bits      = 4;   // 16 sets
    localparam int tag_bits        = 23;

    // word access from a client port
    typedef struct packed {
        logic [word_bits-1:0] addr;
        logic                 read;
        logic                 write;
        logic [mask_bits-1:0] wmask;
        logic [word_bits-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [word_bits-1:0] rdata;
        logic                 resp;   // single-cycle pulse
    } mem_rsp_t;

    // whole-line transfer between cache, arbiter and adaptor
    typedef struct packed {
        logic [word_bits-1:0] addr;   // line aligned
        logic                 read;
        logic                 write;
        logic [line_bits-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic [line_bits-1:0] rdata;
        logic                 resp;
    } line_rsp_t;

    // physical memory beat
    typedef struct packed {
        logic [word_bits-1:0]  addr;
        logic                  read;
        logic                  write;
        logic [burst_bits-1:0] wdata;
    } bmem_req_t;

    typedef struct packed {
        logic [burst_bits-1:0] rdata;
        logic                  resp;  // one per accepted or returned beat
    } bmem_rsp_t;

endpackage : mem_pkg

// ==== verilog/l1_cache.sv ====
`timescale 1ns/10ps

module l1_cache (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::mem_req_t   req_i,
    output mem_pkg::mem_rsp_t   rsp_o,
    output mem_pkg::line_req_t  line_req_o,
    input  mem_pkg::line_rsp_t  line_rsp_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_wback,   // victim line going out
        st_fill,    // new line coming in
        st_resp
    } state_t;

    state_t state_q;

    // storage, one way of 16 sets
    logic [mem_pkg::line_bits-1:0]  data_arr [2**mem_pkg::index_bits];
    logic [mem_pkg::tag_bits-1:0]   tag_arr  [2**mem_pkg::index_bits];
    logic [2**mem_pkg::index_bits-1:0] valid_q;
    logic [2**mem_pkg::index_bits-1:0] dirty_q;

    logic [mem_pkg::word_bits-1:0]  rdata_q;

    // address split
    logic [mem_pkg::tag_bits-1:0]      req_tag;
    logic [mem_pkg::index_bits-1:0]    req_index;
    logic [mem_pkg::offset_bits-3:0]   word_sel;   // word within the line

    logic                           access;
    logic                           hit;
    logic                           victim_dirty;
    logic                           load_line;
    logic [mem_pkg::line_bits-1:0]  cur_line;
    logic [mem_pkg::line_bits-1:0]  src_line;
    logic [mem_pkg::line_bits-1:0]  new_line;

    // byte-masked write of one word into a line
    function automatic logic [mem_pkg::line_bits-1:0] merge_word(
        input logic [mem_pkg::line_bits-1:0]    line,
        input logic [mem_pkg::offset_bits-3:0]  sel,
        input mem_pkg::mem_req_t                req
    );
        logic [mem_pkg::line_bits-1:0] merged;
        merged = line;
        for (int b = 0; b < mem_pkg::mask_bits; b++) begin
            if (req.wmask[b]) begin
                merged[sel*mem_pkg::word_bits + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_tag   = req_i.addr[mem_pkg::word_bits-1 -: mem_pkg::tag_bits];
    assign req_index = req_i.addr[mem_pkg::offset_bits +: mem_pkg::index_bits];
    assign word_sel  = req_i.addr[mem_pkg::offset_bits-1:2];

    assign access       = req_i.read | req_i.write;
    assign cur_line     = data_arr[req_index];
    assign hit          = valid_q[req_index] && (tag_arr[req_index] == req_tag);
    assign victim_dirty = valid_q[req_index] && dirty_q[req_index];

    // a hit works on the stored line, a fill on the returned one
    assign src_line  = (state_q == st_fill) ? line_rsp_i.rdata : cur_line;
    assign new_line  = req_i.write ? merge_word(src_line, word_sel, req_i) : src_line;
    assign load_line = ((state_q == st_idle) && access && hit) ||
                       ((state_q == st_fill) && line_rsp_i.resp);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (access) begin
                        if (hit) begin
                            if (req_i.write) begin
                                dirty_q[req_index] <= 1'b1;
                            end
                            state_q <= st_resp;
                        end else if (victim_dirty) begin
                            state_q <= st_wback;
                        end else begin
                            state_q <= st_fill;
                        end
                    end
                end
                st_wback: begin
                    if (line_rsp_i.resp) begin
                        state_q <= st_fill;
                    end
                end
                st_fill: begin
                    if (line_rsp_i.resp) begin
                        valid_q[req_index] <= 1'b1;
                        dirty_q[req_index] <= req_i.write;   // write-allocate
                        state_q            <= st_resp;
                    end
                end
                default: begin
                    state_q <= st_idle;   // request not sampled in resp cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_line) begin
            rdata_q              <= src_line[word_sel*mem_pkg::word_bits +: mem_pkg::word_bits];
            data_arr[req_index]  <= new_line;
        end
        if ((state_q == st_fill) && line_rsp_i.resp) begin
            tag_arr[req_index] <= req_tag;
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.resp  = (state_q == st_resp);

    always_comb begin
        if (state_q == st_wback) begin
            line_req_o.addr = {tag_arr[req_index], req_index, {mem_pkg::offset_bits{1'b0}}};
        end else begin
            line_req_o.addr = {req_tag, req_index, {mem_pkg::offset_bits{1'b0}}};
        end
        line_req_o.read  = (state_q == st_fill);
        line_req_o.write = (state_q == st_wback);
        line_req_o.wdata = cur_line;   // victim data
    end

endmodule : l1_cache

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::line_req_t  imem_line_req_i,
    output mem_pkg::line_rsp_t  imem_line_rsp_o,
    input  mem_pkg::line_req_t  dmem_line_req_i,
    output mem_pkg::line_rsp_t  dmem_line_rsp_o,
    output mem_pkg::line_req_t  line_req_o,
    input  mem_pkg::line_rsp_t  line_rsp_i
);

    typedef enum logic [1:0] {
        gnt_none,
        gnt_imem,
        gnt_dmem
    } grant_t;

    grant_t grant_q;

    logic imem_wants;
    logic dmem_wants;

    assign imem_wants = imem_line_req_i.read | imem_line_req_i.write;
    assign dmem_wants = dmem_line_req_i.read | dmem_line_req_i.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= gnt_none;
        end else begin
            case (grant_q)
                gnt_none: begin
                    if (dmem_wants) begin
                        grant_q <= gnt_dmem;   // data side first
                    end else if (imem_wants) begin
                        grant_q <= gnt_imem;
                    end
                end
                default: begin
                    if (line_rsp_i.resp) begin
                        grant_q <= gnt_none;   // one idle cycle follows
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (grant_q)
            gnt_imem: line_req_o = imem_line_req_i;
            gnt_dmem: line_req_o = dmem_line_req_i;
            default:  line_req_o = '0;
        endcase
    end

    // data goes to both, resp only to the owner
    assign imem_line_rsp_o.rdata = line_rsp_i.rdata;
    assign imem_line_rsp_o.resp  = line_rsp_i.resp && (grant_q == gnt_imem);
    assign dmem_line_rsp_o.rdata = line_rsp_i.rdata;
    assign dmem_line_rsp_o.resp  = line_rsp_i.resp && (grant_q == gnt_dmem);

endmodule : mem_arbiter

// ==== verilog/cacheline_adaptor.sv ====
`timescale 1ns/10ps

module cacheline_adaptor (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::line_req_t  line_req_i,
    output mem_pkg::line_rsp_t  line_rsp_o,
    output mem_pkg::bmem_req_t  bmem_req_o,
    input  mem_pkg::bmem_rsp_t  bmem_rsp_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write,
        st_done
    } state_t;

    state_t state_q;

    logic [$clog2(mem_pkg::bursts_per_line)-1:0] beat_q;
    logic [mem_pkg::line_bits-1:0]               buf_q;   // shift buffer, beat 0 at the bottom

    logic busy;
    logic last_beat;

    assign busy      = (state_q == st_read) || (state_q == st_write);
    assign last_beat = (beat_q == $clog2(mem_pkg::bursts_per_line)'(mem_pkg::bursts_per_line - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    beat_q <= '0;
                    if (line_req_i.write) begin
                        state_q <= st_write;
                    end else if (line_req_i.read) begin
                        state_q <= st_read;
                    end
                end
                st_read, st_write: begin
                    if (bmem_rsp_i.resp) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= st_done;
                        end
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // writes shift out from the bottom, reads shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            buf_q <= line_req_i.wdata;
        end else if (busy && bmem_rsp_i.resp) begin
            buf_q <= {bmem_rsp_i.rdata, buf_q[mem_pkg::line_bits-1:mem_pkg::burst_bits]};
        end
    end

    assign bmem_req_o.addr  = line_req_i.addr;   // held by the arbiter until line resp
    assign bmem_req_o.read  = (state_q == st_read);
    assign bmem_req_o.write = (state_q == st_write);
    assign bmem_req_o.wdata = buf_q[mem_pkg::burst_bits-1:0];

    assign line_rsp_o.rdata = buf_q;
    assign line_rsp_o.resp  = (state_q == st_done);

endmodule : cacheline_adaptor

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::mem_req_t   imem_req_i,
    output mem_pkg::mem_rsp_t   imem_rsp_o,
    input  mem_pkg::mem_req_t   dmem_req_i,
    output mem_pkg::mem_rsp_t   dmem_rsp_o,
    output mem_pkg::bmem_req_t  bmem_req_o,
    input  mem_pkg::bmem_rsp_t  bmem_rsp_i
);

    mem_pkg::line_req_t imem_line_req;   // imem_cache -> arbiter
    mem_pkg::line_rsp_t imem_line_rsp;
    mem_pkg::line_req_t dmem_line_req;   // dmem_cache -> arbiter
    mem_pkg::line_rsp_t dmem_line_rsp;
    mem_pkg::line_req_t line_req;        // arbiter -> adaptor
    mem_pkg::line_rsp_t line_rsp;

    l1_cache imem_cache (
        .clk        (clk),
        .rst        (rst),
        .req_i      (imem_req_i),
        .rsp_o      (imem_rsp_o),
        .line_req_o (imem_line_req),
        .line_rsp_i (imem_line_rsp)
    );

    l1_cache dmem_cache (
        .clk        (clk),
        .rst        (rst),
        .req_i      (dmem_req_i),
        .rsp_o      (dmem_rsp_o),
        .line_req_o (dmem_line_req),
        .line_rsp_i (dmem_line_rsp)
    );

    mem_arbiter arbiter (
        .clk             (clk),
        .rst             (rst),
        .imem_line_req_i (imem_line_req),
        .imem_line_rsp_o (imem_line_rsp),
        .dmem_line_req_i (dmem_line_req),
        .dmem_line_rsp_o (dmem_line_rsp),
        .line_req_o      (line_req),
        .line_rsp_i      (line_rsp)
    );

    cacheline_adaptor line_adaptor (
        .clk        (clk),
        .rst        (rst),
        .line_req_i (line_req),
        .line_rsp_o (line_rsp),
        .bmem_req_o (bmem_req_o),
        .bmem_rsp_i (bmem_rsp_i)
    );

endmodule : mem_subsystem

// ==== dv/mem_subsystem_properties.sv ====
`timescale 1ns/10ps

module mem_subsystem_properties (
    input logic               clk,
    input logic               rst,
    input mem_pkg::mem_rsp_t  imem_rsp_i,
    input mem_pkg::mem_rsp_t  dmem_rsp_i,
    input mem_pkg::line_req_t imem_line_req_i,
    input mem_pkg::line_rsp_t imem_line_rsp_i,
    input mem_pkg::line_req_t dmem_line_req_i,
    input mem_pkg::line_rsp_t dmem_line_rsp_i,
    input mem_pkg::bmem_req_t bmem_req_i,
    input mem_pkg::bmem_rsp_t bmem_rsp_i
);

    int assert_fails = 0;

    imem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        imem_rsp_i.resp |=> !imem_rsp_i.resp)
        else begin
            $error("imem resp held for more than one cycle");
            assert_fails++;
        end

    dmem_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        dmem_rsp_i.resp |=> !dmem_rsp_i.resp)
        else begin
            $error("dmem resp held for more than one cycle");
            assert_fails++;
        end

    // request and beat data wait for the memory to answer
    bmem_req_hold: assert property (@(posedge clk) disable iff (rst)
        (bmem_req_i.read || bmem_req_i.write) && !bmem_rsp_i.resp |=> $stable(bmem_req_i))
        else begin
            $error("bmem request changed before the memory answered");
            assert_fails++;
        end

    // a line resp goes only to a cache that is asking
    single_grant: assert property (@(posedge clk) disable iff (rst)
        (!imem_line_rsp_i.resp || imem_line_req_i.read || imem_line_req_i.write) &&
        (!dmem_line_rsp_i.resp || dmem_line_req_i.read || dmem_line_req_i.write))
        else begin
            $error("line resp given to a cache that holds no grant");
            assert_fails++;
        end

endmodule : mem_subsystem_properties

bind mem_subsystem mem_subsystem_properties props (
    .clk             (clk),
    .rst             (rst),
    .imem_rsp_i      (imem_rsp_o),
    .dmem_rsp_i      (dmem_rsp_o),
    .imem_line_req_i (imem_line_req),
    .imem_line_rsp_i (imem_line_rsp),
    .dmem_line_req_i (dmem_line_req),
    .dmem_line_rsp_i (dmem_line_rsp),
    .bmem_req_i      (bmem_req_o),
    .bmem_rsp_i      (bmem_rsp_i)
);

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

module tb_mem_subsystem;

    localparam int mem_bytes  = 16384;   // model covers 0x0000..0x3fff
    localparam int max_cycles = 4000;    // about 300 accesses at 12 cycles each
    localparam int rsp_limit  = 200;     // cycles one access may take

    logic               clk;
    logic               rst;
    mem_pkg::mem_req_t  imem_req;
    mem_pkg::mem_rsp_t  imem_rsp;
    mem_pkg::mem_req_t  dmem_req;
    mem_pkg::mem_rsp_t  dmem_rsp;
    mem_pkg::bmem_req_t bmem_req;
    mem_pkg::bmem_rsp_t bmem_rsp;

    logic [7:0]        mem_model [mem_bytes];
    logic [7:0]        shadow [mem_bytes];   // expected contents
    logic [31:0]       traffic_q [$];        // line address of each memory transfer
    mem_pkg::mem_rsp_t got_q [$];
    logic [31:0]       exp_q [$];
    string             what_q [$];

    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    mem_subsystem uut (
        .clk        (clk),
        .rst        (rst),
        .imem_req_i (imem_req),
        .imem_rsp_o (imem_rsp),
        .dmem_req_i (dmem_req),
        .dmem_rsp_o (dmem_rsp),
        .bmem_req_o (bmem_req),
        .bmem_rsp_i (bmem_rsp)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // both address bytes fold into the pattern
    function automatic logic [7:0] init_byte(input logic [31:0] a);
        return (a[7:0] ^ a[15:8]) + 8'h5a;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int a;
        a = int'({addr[13:2], 2'b00});
        return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};   // little endian
    endfunction

    function automatic logic [mem_pkg::line_bits-1:0] line_at(input bit from_model,
                                                           input logic [31:0] addr);
        logic [mem_pkg::line_bits-1:0] line;
        int a;
        a = int'({addr[13:5], 5'd0});
        for (int n = 0; n < 32; n++) begin
            line[n*8 +: 8] = from_model ? mem_model[a + n] : shadow[a + n];
        end
        return line;
    endfunction

    function automatic void shadow_write(input logic [31:0] addr, input logic [3:0] mask,
                                         input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                shadow[int'({addr[13:2], 2'b00}) + b] = data[b*8 +: 8];
            end
        end
    endfunction

    task automatic check_rsp(input mem_pkg::mem_rsp_t rsp, input logic [31:0] exp,
                             input string what);
        if (!rsp.resp || rsp.rdata !== exp) begin
            $display("FAIL %0t: %s read %h, expected %h", $time, what, rsp.rdata, exp);
            error_count++;
        end
    endtask

    task automatic check_line(input logic [mem_pkg::line_bits-1:0] got,
                              input logic [mem_pkg::line_bits-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s line %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_hit(input int lat, input string what);
        if (lat != 1) begin
            $display("FAIL %0t: %s answered after %0d cycles, expected 1", $time, what, lat);
            error_count++;
        end
    endtask

    // compares every read that came back
    always @(posedge clk) begin : compare_proc
        while (got_q.size() > 0) begin
            check_rsp(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
        end
    end

    // burst memory, random gap of 0 to 3 cycles before a beat
    initial begin : memory_model
        int beat;
        int gap;
        int idx;
        beat     = 0;
        gap      = 0;
        bmem_rsp = '0;
        forever begin
            @(posedge clk);
            #2;
            bmem_rsp.resp = 1'b0;
            if (bmem_req.read || bmem_req.write) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    if (beat == 0) begin
                        traffic_q.push_back(bmem_req.addr);
                    end
                    for (int j = 0; j < 8; j++) begin
                        idx = int'(bmem_req.addr[13:0]) + beat * 8 + j;
                        if (bmem_req.read) begin
                            bmem_rsp.rdata[j*8 +: 8] = mem_model[idx];
                        end else begin
                            mem_model[idx] = bmem_req.wdata[j*8 +: 8];
                        end
                    end
                    bmem_rsp.resp = 1'b1;
                    beat          = (beat + 1) % mem_pkg::bursts_per_line;
                    gap           = int'($urandom % 4);
                end
            end else begin
                beat = 0;
            end
        end
    end

    task automatic drive_port(input bit on_dmem, input mem_pkg::mem_req_t req);
        if (on_dmem) begin
            dmem_req = req;
        end else begin
            imem_req = req;
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic access(input bit on_dmem, input bit is_write, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] data, output int lat);
        mem_pkg::mem_req_t req;
        mem_pkg::mem_rsp_t rsp;
        string             what;
        int                waited;
        what      = $sformatf("%s %h", on_dmem ? "dmem" : "imem", addr);
        req.addr  = addr;
        req.read  = !is_write;
        req.write = is_write;
        req.wmask = is_write ? mask : 4'h0;
        req.wdata = data;
        if (is_write) begin
            shadow_write(addr, mask, data);
        end
        drive_port(on_dmem, req);
        waited = 0;
        rsp    = '0;
        while (!rsp.resp && waited < rsp_limit) begin
            @(negedge clk);
            waited++;
            rsp = on_dmem ? dmem_rsp : imem_rsp;
        end
        lat = waited - 1;   // first negedge falls before the sampling edge
        if (!rsp.resp) begin
            $display("%s got no response within %0d cycles", what, rsp_limit);
            error_count++;
        end else if (!is_write) begin
            got_q.push_back(rsp);
            exp_q.push_back(ref_word(addr));
            what_q.push_back(what);
        end
        @(posedge clk);
        #2;
        drive_port(on_dmem, '0);
    endtask

    task automatic random_run(input bit on_dmem, input logic [31:0] base, input int count);
        logic [31:0] addr;
        bit          is_write;
        int          lat;
        for (int i = 0; i < count; i++) begin
            addr     = base + (($urandom % 256) << 2);   // any word of 1 KiB
            is_write = ($urandom % 3) == 0;
            access(on_dmem, is_write, addr, 4'($urandom), $urandom, lat);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        @(posedge clk);
        #2;   // compare process has drained by now
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped at the limit of %0d cycles before the tests ended", max_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin : main_seq
        int lat;
        int lat2;
        int errs;
        void'($urandom(56556));
        rst          = 1'b1;
        imem_req     = '0;
        dmem_req     = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int a = 0; a < mem_bytes; a++) begin
            mem_model[a] = init_byte(32'(a));
            shadow[a]    = init_byte(32'(a));
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        errs = error_count;
        access(1'b0, 1'b0, 32'h0000_0000, 4'h0, 32'h0, lat);
        access(1'b0, 1'b0, 32'h0000_0044, 4'h0, 32'h0, lat);
        access(1'b0, 1'b0, 32'h0000_0104, 4'h0, 32'h0, lat);
        access(1'b1, 1'b0, 32'h0000_2000, 4'h0, 32'h0, lat);
        access(1'b1, 1'b0, 32'h0000_2048, 4'h0, 32'h0, lat);
        access(1'b1, 1'b0, 32'h0000_2110, 4'h0, 32'h0, lat);
        finish_test("initial_read", errs);

        errs = error_count;
        access(1'b1, 1'b1, 32'h0000_2004, 4'b0101, 32'hdead_beef, lat);
        access(1'b1, 1'b0, 32'h0000_2004, 4'h0, 32'h0, lat);
        check_hit(lat, "dmem hit");
        access(1'b0, 1'b1, 32'h0000_0040, 4'b1100, 32'h1234_5678, lat);
        access(1'b0, 1'b0, 32'h0000_0040, 4'h0, 32'h0, lat);
        check_hit(lat, "imem hit");
        finish_test("masked_write", errs);

        errs = error_count;
        access(1'b1, 1'b1, 32'h0000_2024, 4'hf, 32'hcafe_f00d, lat);   // allocates set 1
        access(1'b1, 1'b0, 32'h0000_2224, 4'h0, 32'h0, lat);           // same set, evicts
        check_line(line_at(1'b1, 32'h0000_2020), line_at(1'b0, 32'h0000_2020), "written back");
        access(1'b1, 1'b0, 32'h0000_2024, 4'h0, 32'h0, lat);
        finish_test("eviction", errs);

        errs = error_count;
        traffic_q.delete();
        fork
            access(1'b0, 1'b0, 32'h0000_0300, 4'h0, 32'h0, lat);
            access(1'b1, 1'b0, 32'h0000_2500, 4'h0, 32'h0, lat2);
        join
        if (traffic_q.size() < 2 || traffic_q[0] < 32'h0000_2000) begin
            $display("FAIL %0t: data side did not reach memory first", $time);
            error_count++;
        end
        finish_test("both_ports", errs);

        errs = error_count;
        fork
            random_run(1'b0, 32'h0000_1000, 140);
            random_run(1'b1, 32'h0000_3000, 140);
        join
        finish_test("random", errs);

        if (uut.props.assert_fails != 0) begin
            $display("concurrent assertions failed %0d times", uut.props.assert_fails);
            error_count++;
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

// ==== list.f ====
verilog/mem_pkg.sv
verilog/l1_cache.sv
verilog/mem_arbiter.sv
verilog/cacheline_adaptor.sv
verilog/mem_subsystem.sv
dv/mem_subsystem_properties.sv
dv/tb_mem_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_mem_subsystem -o sim_mem_subsystem
./obj_dir/sim_mem_subsystem | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
